// File: rtl/kitchen_pkg.sv
`default_nettype none

package kitchen_pkg;

    // board size in cells
    localparam int grid_rows = 8;
    localparam int grid_cols = 13;

    localparam int cell_px = 32; // pixels per cell side

    typedef enum logic [3:0] {
        g_empty         = 4'd0,
        g_onion_whole   = 4'd1,
        g_onion_chopped = 4'd2,
        g_bowl_empty    = 4'd3,
        g_bowl_full     = 4'd4,
        g_pot_empty     = 4'd5,
        g_pot_raw       = 4'd6,
        g_pot_cooked    = 4'd7,
        g_fire          = 4'd8,
        g_extinguisher  = 4'd9
    } obj_t;

    typedef enum logic [3:0] {
        p_nothing       = 4'd0,
        p_chopping      = 4'd1,
        p_onion_whole   = 4'd2,
        p_onion_chopped = 4'd3,
        p_pot_empty     = 4'd4,
        p_pot_raw       = 4'd5,
        p_pot_cooked    = 4'd6,
        p_bowl_empty    = 4'd7,
        p_bowl_full     = 4'd8,
        p_ext_off       = 4'd9,
        p_ext_on        = 4'd10
    } hold_t;

    typedef enum logic [1:0] {
        dir_left  = 2'd0,
        dir_right = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        s_idle   = 2'd0,
        s_raw    = 2'd1,
        s_cooked = 2'd2,
        s_fire   = 2'd3
    } stove_t;

    // fixed cells, rows count down from the top
    localparam int onion_row = 0;
    localparam int onion_col [2] = '{2, 3};
    localparam int bowl_row = 6;
    localparam int bowl_col = 12;
    localparam int board_row = 7;
    localparam int board_col [2] = '{2, 4};
    localparam int stove_row = 0;  // also the row that fire travels along
    localparam int stove_col0 = 8; // stoves sit at cols 8..11
    localparam int serve_row [2] = '{5, 4};
    localparam int serve_col = 12;
    localparam int ext_row = 0;
    localparam int ext_col = 7;

endpackage

`default_nettype wire

// File: rtl/countdown_timer.sv
`default_nettype none
`timescale 1ns/100ps

module countdown_timer #(
    parameter int frames_per_unit = 60,
    parameter int given_time = 10
) (
    input  wire logic vsync,
    input  wire logic reset,
    input  wire logic go,
    input  wire logic restart,
    output logic [3:0] time_left
);

    localparam int pw = (frames_per_unit > 1) ? $clog2(frames_per_unit) : 1;

    logic [pw-1:0] frame_cnt; // frames into the current unit

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            frame_cnt <= '0;
            time_left <= 4'(given_time);
        end else if (go && time_left != 4'd0) begin
            if (frame_cnt == pw'(frames_per_unit - 1)) begin
                frame_cnt <= '0;
                time_left <= time_left - 4'd1;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/grid_locator.sv
`default_nettype none
`timescale 1ns/100ps

module grid_locator (
    input  wire logic [8:0]        player_x,
    input  wire logic [8:0]        player_y,
    input  wire kitchen_pkg::dir_t facing,
    output logic [3:0]             cell_x,
    output logic [2:0]             cell_y,
    output logic [3:0]             front_x,
    output logic [2:0]             front_y
);
    import kitchen_pkg::*;

    logic [9:0] centre_x;
    logic [9:0] centre_y;
    logic [4:0] col_raw;
    logic [4:0] row_raw;

    // sprite origin is its corner, so round to the nearest cell
    assign centre_x = {1'b0, player_x} + 10'(cell_px / 2);
    assign centre_y = {1'b0, player_y} + 10'(cell_px / 2);
    assign col_raw = 5'(centre_x / cell_px);
    assign row_raw = 5'(centre_y / cell_px);

    // keep the cell on the board
    assign cell_x = (col_raw > 5'(grid_cols - 1)) ? 4'(grid_cols - 1) : col_raw[3:0];
    assign cell_y = (row_raw > 5'(grid_rows - 1)) ? 3'(grid_rows - 1) : row_raw[2:0];

    always_comb begin
        front_x = cell_x;
        front_y = cell_y;
        case (facing)
            dir_left:  front_x = (cell_x == 4'd0) ? cell_x : cell_x - 4'd1;
            dir_right: front_x = (cell_x == 4'(grid_cols - 1)) ? cell_x : cell_x + 4'd1;
            dir_up:    front_y = (cell_y == 3'd0) ? cell_y : cell_y - 3'd1;
            dir_down:  front_y = (cell_y == 3'(grid_rows - 1)) ? cell_y : cell_y + 3'd1;
            default:   front_x = cell_x;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/stove_controller.sv
`default_nettype none
`timescale 1ns/100ps

module stove_controller #(
    parameter int frames_per_unit = 60,
    parameter int cook_time = 10,
    parameter int burn_time = 10
) (
    input  wire logic              vsync,
    input  wire logic              reset,
    input  wire kitchen_pkg::obj_t pot_cell,
    output logic                   set_valid,
    output kitchen_pkg::obj_t      set_code,
    output logic                   spread_tick,
    output logic [3:0]             time_left
);
    import kitchen_pkg::*;

    stove_t phase;
    logic cook_go;
    logic cook_restart;
    logic burn_go;
    logic burn_restart;
    logic [3:0] cook_left;
    logic [3:0] burn_left;
    logic cook_done;
    logic burn_done;

    countdown_timer #(
        .frames_per_unit(frames_per_unit),
        .given_time(cook_time)
    ) cook_timer_i (
        .vsync(vsync),
        .reset(reset),
        .go(cook_go),
        .restart(cook_restart),
        .time_left(cook_left)
    );

    countdown_timer #(
        .frames_per_unit(frames_per_unit),
        .given_time(burn_time)
    ) burn_timer_i (
        .vsync(vsync),
        .reset(reset),
        .go(burn_go),
        .restart(burn_restart),
        .time_left(burn_left)
    );

    assign cook_done = (phase == s_raw) && (pot_cell == g_pot_raw) && (cook_left == 4'd0);
    assign burn_done = (phase == s_cooked) && (pot_cell == g_pot_cooked) && (burn_left == 4'd0);
    assign spread_tick = (phase == s_fire) && (pot_cell == g_fire) && (burn_left == 4'd0);

    assign set_valid = cook_done || burn_done;
    assign set_code = burn_done ? g_fire : g_pot_cooked;

    assign cook_go = (phase == s_raw);
    assign cook_restart = (phase != s_raw);
    // burn timer also paces the spread while burning
    assign burn_go = (phase == s_cooked) || (phase == s_fire);
    assign burn_restart = !burn_go || burn_done || spread_tick;

    // shows whichever timer is running
    assign time_left = burn_go ? burn_left : cook_left;

    always_ff @(posedge vsync) begin
        if (reset) begin
            phase <= s_idle;
        end else begin
            case (phase)
                s_idle:   if (pot_cell == g_pot_raw) phase <= s_raw;
                s_raw:    if (pot_cell != g_pot_raw) phase <= s_idle;
                          else if (cook_done) phase <= s_cooked;
                s_cooked: if (pot_cell != g_pot_cooked) phase <= s_idle;
                          else if (burn_done) phase <= s_fire;
                s_fire:   if (pot_cell != g_fire) phase <= s_idle; // put out
                default:  phase <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/player_action.sv
`default_nettype none
`timescale 1ns/100ps

module player_action #(
    parameter int frames_per_unit = 60,
    parameter int chop_time = 5
) (
    input  wire logic                    vsync,
    input  wire logic                    reset,
    input  wire logic                    carry,
    input  wire logic                    chop,
    input  wire logic [1:0]              serve_clear,
    input  wire logic [3:0]              cell_x,
    input  wire logic [2:0]              cell_y,
    input  wire logic [3:0]              front_x,
    input  wire logic [2:0]              front_y,
    input  wire logic [3:0]              set_valid,
    input  wire kitchen_pkg::obj_t [3:0] set_code,
    input  wire logic [3:0]              spread_tick,
    output kitchen_pkg::hold_t           player_state,
    output kitchen_pkg::obj_t [kitchen_pkg::grid_rows-1:0][kitchen_pkg::grid_cols-1:0]
                                         object_grid,
    output logic [1:0][3:0]              board_time,
    output kitchen_pkg::obj_t [3:0]      pot_cell
);
    import kitchen_pkg::*;

    obj_t [grid_rows-1:0][grid_cols-1:0] next_grid;
    hold_t next_state;
    obj_t in_front;
    obj_t held_code;
    obj_t clear_code;
    obj_t p_code;
    logic p_wr;
    logic at_disp;
    logic can_drop;
    logic combine_raw;
    logic [1:0] board_go;
    logic [1:0] board_restart;
    logic [1:0] chop_done;

    assign in_front = object_grid[front_y][front_x];

    // a dispenser refills itself whenever its item is taken or cleared
    assign at_disp = ((front_y == 3'(onion_row)) &&
                      (front_x == 4'(onion_col[0]) || front_x == 4'(onion_col[1]))) ||
                     ((front_y == 3'(bowl_row)) && (front_x == 4'(bowl_col)));
    assign clear_code = !at_disp ? g_empty :
                        (front_y == 3'(bowl_row)) ? g_bowl_empty : g_onion_whole;

    assign can_drop = !carry && (in_front == g_empty);
    assign combine_raw = ((player_state == p_onion_chopped) && (in_front == g_pot_empty)) ||
                         ((player_state == p_pot_empty) && (in_front == g_onion_chopped));

    always_comb begin
        for (int s = 0; s < 4; s++) begin
            pot_cell[s] = object_grid[stove_row][stove_col0 + s];
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_board
        // standing just above the board and facing it
        assign board_go[b] = (player_state == p_chopping) && chop &&
                             (cell_y == 3'(board_row - 1)) && (cell_x == 4'(board_col[b])) &&
                             (front_y == 3'(board_row)) && (front_x == 4'(board_col[b])) &&
                             (object_grid[board_row][board_col[b]] == g_onion_whole);
        assign board_restart[b] = (object_grid[board_row][board_col[b]] != g_onion_whole);
        assign chop_done[b] = board_go[b] && (board_time[b] == 4'd0);

        countdown_timer #(
            .frames_per_unit(frames_per_unit),
            .given_time(chop_time)
        ) board_timer_i (
            .vsync(vsync),
            .reset(reset),
            .go(board_go[b]),
            .restart(board_restart[b]),
            .time_left(board_time[b])
        );
    end

    always_comb begin
        case (player_state)
            p_onion_whole:   held_code = g_onion_whole;
            p_onion_chopped: held_code = g_onion_chopped;
            p_pot_empty:     held_code = g_pot_empty;
            p_pot_raw:       held_code = g_pot_raw;
            p_pot_cooked:    held_code = g_pot_cooked;
            p_bowl_empty:    held_code = g_bowl_empty;
            p_bowl_full:     held_code = g_bowl_full;
            p_ext_off:       held_code = g_extinguisher;
            default:         held_code = g_empty;
        endcase
    end

    // hold state machine and the write it makes to the cell in front
    always_comb begin
        next_state = player_state;
        p_wr = 1'b0;
        p_code = clear_code;
        case (player_state)
            p_nothing: begin
                if (chop) begin
                    next_state = p_chopping;
                end else if (carry) begin
                    p_wr = 1'b1; // pick up
                    case (in_front)
                        g_onion_whole:   next_state = p_onion_whole;
                        g_onion_chopped: next_state = p_onion_chopped;
                        g_pot_empty:     next_state = p_pot_empty;
                        g_pot_raw:       next_state = p_pot_raw;
                        g_pot_cooked:    next_state = p_pot_cooked;
                        g_bowl_empty:    next_state = p_bowl_empty;
                        g_bowl_full:     next_state = p_bowl_full;
                        g_extinguisher:  next_state = p_ext_off;
                        default:         p_wr = 1'b0;
                    endcase
                end
            end
            p_chopping: begin
                if (!chop) begin
                    next_state = p_nothing;
                end
            end
            p_ext_on: begin
                if (!chop) begin
                    next_state = p_ext_off;
                end else begin
                    p_wr = 1'b1; // spraying clears the cell
                end
            end
            default: begin
                if (!carry && combine_raw) begin
                    next_state = p_nothing;
                    p_wr = 1'b1;
                    p_code = g_pot_raw;
                end else if (!carry && (player_state == p_pot_cooked) &&
                             (in_front == g_bowl_empty) && !at_disp) begin
                    next_state = p_pot_empty; // serve into the bowl, keep the pot
                    p_wr = 1'b1;
                    p_code = g_bowl_full;
                end else if (can_drop) begin
                    next_state = p_nothing;
                    p_wr = 1'b1;
                    p_code = held_code;
                end else if ((player_state == p_ext_off) && chop) begin
                    next_state = p_ext_on;
                end
            end
        endcase
    end

    // lowest priority first, later writes win
    always_comb begin
        next_grid = object_grid;
        if (|spread_tick) begin
            for (int c = 0; c < grid_cols; c++) begin
                if (object_grid[stove_row][c] == g_fire) begin
                    if (c > 0) begin
                        next_grid[stove_row][c-1] = g_fire;
                    end
                    if (c < grid_cols - 1) begin
                        next_grid[stove_row][c+1] = g_fire;
                    end
                end
            end
        end
        for (int s = 0; s < 4; s++) begin
            if (set_valid[s]) begin
                next_grid[stove_row][stove_col0 + s] = set_code[s];
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (serve_clear[k]) begin
                next_grid[serve_row[k]][serve_col] = g_empty;
            end
        end
        for (int b = 0; b < 2; b++) begin
            if (chop_done[b]) begin
                next_grid[board_row][board_col[b]] = g_onion_chopped;
            end
        end
        if (p_wr) begin
            next_grid[front_y][front_x] = p_code;
        end
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            player_state <= p_nothing;
            for (int r = 0; r < grid_rows; r++) begin
                for (int c = 0; c < grid_cols; c++) begin
                    object_grid[r][c] <= g_empty;
                end
            end
            object_grid[onion_row][onion_col[0]] <= g_onion_whole;
            object_grid[onion_row][onion_col[1]] <= g_onion_whole;
            object_grid[bowl_row][bowl_col] <= g_bowl_empty;
            object_grid[ext_row][ext_col] <= g_extinguisher;
            for (int s = 0; s < 4; s++) begin
                object_grid[stove_row][stove_col0 + s] <= g_pot_empty;
            end
        end else begin
            player_state <= next_state;
            object_grid <= next_grid;
        end
    end

endmodule

`default_nettype wire

// File: rtl/kitchen_top.sv
`default_nettype none
`timescale 1ns/100ps

module kitchen_top #(
    parameter int frames_per_unit = 60,
    parameter int chop_time = 5,
    parameter int cook_time = 10,
    parameter int burn_time = 10
) (
    input  wire logic              vsync,
    input  wire logic              reset,
    input  wire logic [8:0]        player_x,
    input  wire logic [8:0]        player_y,
    input  wire kitchen_pkg::dir_t facing,
    input  wire logic              carry,
    input  wire logic              chop,
    input  wire logic [1:0]        serve_clear,
    output kitchen_pkg::hold_t     player_state,
    output kitchen_pkg::obj_t [kitchen_pkg::grid_rows-1:0][kitchen_pkg::grid_cols-1:0]
                                   object_grid,
    output logic [5:0][3:0]        time_grid
);
    import kitchen_pkg::*;

    logic [3:0] cell_x;
    logic [2:0] cell_y;
    logic [3:0] front_x;
    logic [2:0] front_y;
    obj_t [3:0] pot_cell;
    logic [3:0] set_valid;
    obj_t [3:0] set_code;
    logic [3:0] spread_tick;
    logic [1:0][3:0] board_time;
    logic [3:0][3:0] stove_time;

    grid_locator grid_locator_i (
        .player_x(player_x),
        .player_y(player_y),
        .facing(facing),
        .cell_x(cell_x),
        .cell_y(cell_y),
        .front_x(front_x),
        .front_y(front_y)
    );

    player_action #(
        .frames_per_unit(frames_per_unit),
        .chop_time(chop_time)
    ) player_action_i (
        .vsync(vsync),
        .reset(reset),
        .carry(carry),
        .chop(chop),
        .serve_clear(serve_clear),
        .cell_x(cell_x),
        .cell_y(cell_y),
        .front_x(front_x),
        .front_y(front_y),
        .set_valid(set_valid),
        .set_code(set_code),
        .spread_tick(spread_tick),
        .player_state(player_state),
        .object_grid(object_grid),
        .board_time(board_time),
        .pot_cell(pot_cell)
    );

    for (genvar s = 0; s < 4; s++) begin : g_stove
        stove_controller #(
            .frames_per_unit(frames_per_unit),
            .cook_time(cook_time),
            .burn_time(burn_time)
        ) stove_controller_i (
            .vsync(vsync),
            .reset(reset),
            .pot_cell(pot_cell[s]),
            .set_valid(set_valid[s]),
            .set_code(set_code[s]),
            .spread_tick(spread_tick[s]),
            .time_left(stove_time[s])
        );
    end

    // board 1 in the top slot, stove 4 in the bottom one
    assign time_grid = {board_time[0], board_time[1],
                        stove_time[0], stove_time[1], stove_time[2], stove_time[3]};

endmodule

`default_nettype wire

// File: tests/kitchen_model.svh
`ifndef KITCHEN_MODEL_SVH
`define KITCHEN_MODEL_SVH

// timers 0..1 chop boards, 2..5 stove cook, 6..9 stove burn
logic [3:0] m_grid [grid_rows][grid_cols];
logic [3:0] m_hold;
logic [1:0] m_phase [4];
int m_left [10];
int m_frames [10];

function automatic int timer_len(input int idx);
    return (idx < 2) ? t_chop : (idx < 6) ? t_cook : t_burn;
endfunction

task automatic reset_model();
    for (int r = 0; r < grid_rows; r++) begin
        for (int c = 0; c < grid_cols; c++) begin
            m_grid[r][c] = g_empty;
        end
    end
    m_grid[0][2] = g_onion_whole;
    m_grid[0][3] = g_onion_whole;
    m_grid[6][12] = g_bowl_empty;
    m_grid[0][7] = g_extinguisher;
    for (int s = 0; s < 4; s++) begin
        m_grid[0][8 + s] = g_pot_empty; // stoves start with empty pots
        m_phase[s] = s_idle;
    end
    for (int i = 0; i < 10; i++) begin
        m_left[i] = timer_len(i);
        m_frames[i] = 0;
    end
    m_hold = p_nothing;
endtask

task automatic count_down(input int idx, input logic go, input logic restart);
    if (restart) begin
        m_frames[idx] = 0;
        m_left[idx] = timer_len(idx);
    end else if (go && m_left[idx] != 0) begin
        if (m_frames[idx] == fpu - 1) begin
            m_frames[idx] = 0;
            m_left[idx] = m_left[idx] - 1;
        end else begin
            m_frames[idx] = m_frames[idx] + 1;
        end
    end
endtask

function automatic logic [3:0] pick_state(input logic [3:0] obj);
    case (obj)
        g_onion_whole:   return p_onion_whole;
        g_onion_chopped: return p_onion_chopped;
        g_pot_empty:     return p_pot_empty;
        g_pot_raw:       return p_pot_raw;
        g_pot_cooked:    return p_pot_cooked;
        g_bowl_empty:    return p_bowl_empty;
        g_bowl_full:     return p_bowl_full;
        g_extinguisher:  return p_ext_off;
        default:         return p_nothing; // nothing to pick up
    endcase
endfunction

function automatic logic [3:0] held_object(input logic [3:0] hold);
    case (hold)
        p_onion_whole:   return g_onion_whole;
        p_onion_chopped: return g_onion_chopped;
        p_pot_empty:     return g_pot_empty;
        p_pot_raw:       return g_pot_raw;
        p_pot_cooked:    return g_pot_cooked;
        p_bowl_empty:    return g_bowl_empty;
        p_bowl_full:     return g_bowl_full;
        p_ext_off:       return g_extinguisher;
        default:         return g_empty;
    endcase
endfunction

// slot k: boards then stoves, a stove shows its burn timer once cooked
function automatic int shown_time(input int k);
    if (k < 2) begin
        return m_left[k];
    end
    if (m_phase[k - 2] == s_cooked || m_phase[k - 2] == s_fire) begin
        return m_left[4 + k];
    end
    return m_left[k];
endfunction

task automatic step_model(input logic carry_now, input logic chop_now,
                          input logic [1:0] serve_now, input int cy, input int cx,
                          input logic [1:0] face);
    logic [3:0] nxt [grid_rows][grid_cols];
    logic [3:0] front;
    logic [3:0] clr;
    logic [3:0] code;
    logic [3:0] nstate;
    logic [3:0] pot;
    logic [3:0] set_c [4];
    logic [3:0] set_v;
    logic [3:0] spread;
    logic [1:0] b_done;
    logic disp;
    logic wr;
    logic go;
    logic cook_end;
    logic burn_end;
    logic burning;
    int fx;
    int fy;
    int bc;

    fx = cx;
    fy = cy;
    case (face)
        dir_left:  if (cx > 0) fx = cx - 1;
        dir_right: if (cx < grid_cols - 1) fx = cx + 1;
        dir_up:    if (cy > 0) fy = cy - 1;
        default:   if (cy < grid_rows - 1) fy = cy + 1;
    endcase
    front = m_grid[fy][fx];
    disp = (fy == 0 && (fx == 2 || fx == 3)) || (fy == 6 && fx == 12);
    clr = !disp ? g_empty : (fy == 6) ? g_bowl_empty : g_onion_whole;

    for (int s = 0; s < 4; s++) begin
        pot = m_grid[0][8 + s];
        cook_end = m_phase[s] == s_raw && pot == g_pot_raw && m_left[2 + s] == 0;
        burn_end = m_phase[s] == s_cooked && pot == g_pot_cooked && m_left[6 + s] == 0;
        spread[s] = m_phase[s] == s_fire && pot == g_fire && m_left[6 + s] == 0;
        set_v[s] = cook_end || burn_end;
        set_c[s] = burn_end ? g_fire : g_pot_cooked;
        burning = m_phase[s] == s_cooked || m_phase[s] == s_fire;
        count_down(2 + s, m_phase[s] == s_raw, m_phase[s] != s_raw);
        count_down(6 + s, burning, !burning || burn_end || spread[s]);
        case (m_phase[s])
            s_idle:   if (pot == g_pot_raw) m_phase[s] = s_raw;
            s_raw:    m_phase[s] = (pot != g_pot_raw) ? s_idle : cook_end ? s_cooked : s_raw;
            s_cooked: m_phase[s] = (pot != g_pot_cooked) ? s_idle : burn_end ? s_fire : s_cooked;
            default:  if (pot != g_fire) m_phase[s] = s_idle;
        endcase
    end

    for (int b = 0; b < 2; b++) begin
        bc = (b == 0) ? 2 : 4;
        go = m_hold == p_chopping && chop_now && cy == 6 && cx == bc && fy == 7 && fx == bc &&
             m_grid[7][bc] == g_onion_whole;
        b_done[b] = go && m_left[b] == 0;
        count_down(b, go, m_grid[7][bc] != g_onion_whole);
    end

    nstate = m_hold;
    wr = 1'b0;
    code = clr;
    if (m_hold == p_nothing) begin
        if (chop_now) begin
            nstate = p_chopping;
        end else if (carry_now && pick_state(front) != p_nothing) begin
            nstate = pick_state(front);
            wr = 1'b1;
        end
    end else if (m_hold == p_chopping) begin
        if (!chop_now) nstate = p_nothing;
    end else if (m_hold == p_ext_on) begin
        if (!chop_now) nstate = p_ext_off;
        else wr = 1'b1; // spray clears the cell
    end else if (!carry_now && ((m_hold == p_onion_chopped && front == g_pot_empty) ||
                                (m_hold == p_pot_empty && front == g_onion_chopped))) begin
        nstate = p_nothing;
        wr = 1'b1;
        code = g_pot_raw;
    end else if (!carry_now && m_hold == p_pot_cooked && front == g_bowl_empty && !disp) begin
        nstate = p_pot_empty;
        wr = 1'b1;
        code = g_bowl_full;
    end else if (!carry_now && front == g_empty) begin
        nstate = p_nothing;
        wr = 1'b1;
        code = held_object(m_hold);
    end else if (m_hold == p_ext_off && chop_now) begin
        nstate = p_ext_on;
    end

    // later writes win, the player last
    nxt = m_grid;
    if (spread != 4'b0000) begin
        for (int c = 0; c < grid_cols; c++) begin
            if (m_grid[0][c] == g_fire) begin
                if (c > 0) nxt[0][c - 1] = g_fire;
                if (c < grid_cols - 1) nxt[0][c + 1] = g_fire;
            end
        end
    end
    for (int s = 0; s < 4; s++) begin
        if (set_v[s]) nxt[0][8 + s] = set_c[s];
    end
    if (serve_now[0]) nxt[5][12] = g_empty;
    if (serve_now[1]) nxt[4][12] = g_empty;
    if (b_done[0]) nxt[7][2] = g_onion_chopped;
    if (b_done[1]) nxt[7][4] = g_onion_chopped;
    if (wr) nxt[fy][fx] = code;
    m_grid = nxt;
    m_hold = nstate;
endtask

`endif

// File: tests/kitchen_tb.sv
`default_nettype none
`timescale 1ns/100ps

module kitchen_tb;
    import kitchen_pkg::*;

    localparam int fpu = 4;
    localparam int t_chop = 2;
    localparam int t_cook = 3;
    localparam int t_burn = 3;
    localparam int n_cycles = 6000;
    localparam int clk_period = 4;

    // standing spots beside dispensers, boards, stoves, serving cells, extinguisher and floor
    localparam int spot_row [16] = '{1, 1, 6, 6, 1, 1, 1, 1, 5, 4, 6, 1, 3, 2, 0, 7};
    localparam int spot_col [16] = '{2, 3, 2, 4, 8, 9, 10, 11, 11, 11, 11, 7, 5, 6, 5, 0};
    localparam int spot_dir [16] = '{2, 2, 3, 3, 2, 2, 2, 2, 1, 1, 1, 2, 0, 3, 1, 0};

    logic vsync = 1'b0;
    logic reset;
    logic [8:0] player_x;
    logic [8:0] player_y;
    dir_t facing;
    logic carry;
    logic chop;
    logic [1:0] serve_clear;
    hold_t player_state;
    obj_t [grid_rows-1:0][grid_cols-1:0] object_grid;
    logic [5:0][3:0] time_grid;

    logic [31:0] lfsr = 32'd93675;
    int errors;
    int checks;
    int cur_row;
    int cur_col;

    `include "kitchen_model.svh"

    kitchen_top #(
        .frames_per_unit(fpu),
        .chop_time(t_chop),
        .cook_time(t_cook),
        .burn_time(t_burn)
    ) kitchen_top_i (
        .vsync(vsync),
        .reset(reset),
        .player_x(player_x),
        .player_y(player_y),
        .facing(facing),
        .carry(carry),
        .chop(chop),
        .serve_clear(serve_clear),
        .player_state(player_state),
        .object_grid(object_grid),
        .time_grid(time_grid)
    );

    always #(clk_period / 2) vsync = ~vsync;

    // taps 32, 22, 2, 1
    function logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task check_outputs();
        for (int r = 0; r < grid_rows; r++) begin
            for (int c = 0; c < grid_cols; c++) begin
                if (object_grid[r][c] !== m_grid[r][c]) begin
                    errors++;
                    $display("[FAIL] %0t ns: cell row %0d col %0d is %0d, expected %0d",
                             $time, r, c, object_grid[r][c], m_grid[r][c]);
                end
            end
        end
        if (player_state !== m_hold) begin
            errors++;
            $display("[FAIL] %0t ns: player_state is %0d, expected %0d",
                     $time, player_state, m_hold);
        end
        for (int k = 0; k < 6; k++) begin
            if (time_grid[5 - k] !== 4'(shown_time(k))) begin
                errors++;
                $display("[FAIL] %0t ns: time_grid slot %0d is %0d, expected %0d",
                         $time, k, time_grid[5 - k], shown_time(k));
            end
        end
        checks++;
    endtask

    initial begin
        int spot;
        int dwell;

        errors = 0;
        checks = 0;
        reset = 1'b1;
        player_x = '0;
        player_y = '0;
        facing = dir_left;
        carry = 1'b0;
        chop = 1'b0;
        serve_clear = 2'b00;
        cur_row = 0;
        cur_col = 0;
        dwell = 0;
        repeat (3) @(posedge vsync);
        reset <= 1'b0;
        reset_model();
        @(negedge vsync);
        check_outputs(); // start layout and full timers

        for (int n = 0; n < n_cycles; n++) begin
            @(posedge vsync);
            step_model(carry, chop, serve_clear, cur_row, cur_col, facing);
            if (dwell == 0) begin
                spot = int'(take_bits(4));
                cur_row = spot_row[spot];
                cur_col = spot_col[spot];
                // jitter under half a cell keeps the same grid cell
                player_x <= 9'(cur_col * cell_px + take_bits(4));
                player_y <= 9'(cur_row * cell_px + take_bits(4));
                facing <= (take_bits(3) == 0) ? dir_t'(take_bits(2)) : dir_t'(spot_dir[spot]);
                carry <= 1'(take_bits(1));
                chop <= (take_bits(2) == 0);
                serve_clear <= (take_bits(3) == 0) ? 2'(take_bits(2)) : 2'b00;
                dwell = int'(take_bits(4)); // hold the inputs a while
            end else begin
                dwell--;
            end
            @(negedge vsync);
            check_outputs();
        end

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #((n_cycles + 20) * clk_period + 100);
        $display("timeout: the stimulus loop did not finish in the expected time");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
rtl/kitchen_pkg.sv
rtl/countdown_timer.sv
rtl/grid_locator.sv
rtl/stove_controller.sv
rtl/player_action.sv
rtl/kitchen_top.sv
tests/kitchen_tb.sv
